// File: source/conv_pkg.sv
package conv_pkg;

    // Array and FIFO sizing
    localparam int NUM_PE     = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // Wishbone word address map
    localparam logic [1:0] ADR_OPERAND = 2'd0;
    localparam logic [1:0] ADR_RESULT  = 2'd1;
    localparam logic [1:0] ADR_STATUS  = 2'd2;
    localparam logic [1:0] ADR_CLEAR   = 2'd3;

    // One operand beat, psum in the upper half
    typedef struct packed {
        logic signed [15:0] psum;
        logic signed [7:0]  fltr;
        logic signed [7:0]  ifmap;
    } operand_t;

    typedef struct packed {
        logic [15:0]        zero;
        logic signed [15:0] value;
    } result_t;

    // Status flags, overflow at bit 0
    typedef struct packed {
        logic [27:0] pad;
        logic        res_avail;
        logic        buf_empty;
        logic        underflow;
        logic        overflow;
    } status_t;

    // Read data word, meaning depends on the address read
    typedef union packed {
        result_t result;
        status_t status;
    } bus_word_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        bus_word_u dat;
    } wb_rsp_t;

    typedef struct packed {
        logic     valid;
        operand_t operand;
    } pe_op_t;

    typedef struct packed {
        logic               valid;
        logic signed [15:0] value;
    } pe_res_t;

endpackage

// File: source/async_fifo.sv
module async_fifo
    import conv_pkg::*;
(
    input  logic             wr_clk,
    input  logic             rd_clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [31:0]      wr_data,
    output logic             full,
    output logic [FIFO_AW:0] wr_level,
    input  logic             rd_en,
    output logic [31:0]      rd_data,
    output logic             empty,
    output logic             empty_sync
);

    logic [31:0] mem [FIFO_DEPTH];

    // Pointers carry one extra wrap bit
    logic [FIFO_AW:0] wbin;
    logic [FIFO_AW:0] wgray;
    logic [FIFO_AW:0] wbin_next;
    logic [FIFO_AW:0] rbin;
    logic [FIFO_AW:0] rgray;
    logic [FIFO_AW:0] rbin_next;
    // Gray pointers after two flops on the far side
    logic [FIFO_AW:0] wgray_s1;
    logic [FIFO_AW:0] wgray_s2;
    logic [FIFO_AW:0] rgray_s1;
    logic [FIFO_AW:0] rgray_s2;
    logic             wr_ok;
    logic             rd_ok;

    function automatic logic [FIFO_AW:0] gray2bin(input logic [FIFO_AW:0] g);
        logic [FIFO_AW:0] b;
        b[FIFO_AW] = g[FIFO_AW];
        for (int i = FIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i + 1] ^ g[i];
        end
        return b;
    endfunction

    // Blocked accesses are simply ignored
    assign wr_ok     = wr_en && !full;
    assign rd_ok     = rd_en && !empty;
    assign wbin_next = wbin + 1'b1;
    assign rbin_next = rbin + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Write domain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (wr_ok) begin
            wbin  <= wbin_next;
            wgray <= wbin_next ^ (wbin_next >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_ok) begin
            mem[wbin[FIFO_AW-1:0]] <= wr_data;
        end
    end

    // Read pointer into write domain
    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            rgray_s1 <= '0;
            rgray_s2 <= '0;
        end else begin
            rgray_s1 <= rgray;
            rgray_s2 <= rgray_s1;
        end
    end

    // Full when the top two Gray bits differ and the rest match
    assign full = (wgray == {~rgray_s2[FIFO_AW:FIFO_AW-1], rgray_s2[FIFO_AW-2:0]});
    // Level is pessimistic, reads show up two cycles late
    assign wr_level   = wbin - gray2bin(rgray_s2);
    assign empty_sync = (wgray == rgray_s2);

    //////////////////////////////////////////////////////////////////////
    // Read domain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rbin  <= '0;
            rgray <= '0;
        end else if (rd_ok) begin
            rbin  <= rbin_next;
            rgray <= rbin_next ^ (rbin_next >> 1);
        end
    end

    // Data lands one cycle after the pop
    always_ff @(posedge rd_clk) begin
        if (rd_ok) begin
            rd_data <= mem[rbin[FIFO_AW-1:0]];
        end
    end

    // Write pointer into read domain
    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            wgray_s1 <= '0;
            wgray_s2 <= '0;
        end else begin
            wgray_s1 <= wgray;
            wgray_s2 <= wgray_s1;
        end
    end

    assign empty = (rgray == wgray_s2);

endmodule

// File: source/ccd_buffer.sv
module ccd_buffer
    import conv_pkg::*;
(
    input  logic     bus_clk,
    input  logic     pe_clk,
    input  logic     arst_n,
    input  logic     push,
    input  operand_t wr_data,
    output logic     full,
    input  logic     pop,
    output operand_t rd_data,
    output logic     empty,
    output logic     empty_sync
);

    // Lane 0 ifmap, lane 1 filter, lane 2 psum
    logic [2:0][31:0] wr_word;
    logic [2:0][31:0] rd_word;
    logic [2:0]       full_v;
    logic [2:0]       empty_v;
    logic [2:0]       empty_sync_v;

    // Split the beat, one field per FIFO
    assign wr_word[0] = {24'd0, wr_data.ifmap};
    assign wr_word[1] = {24'd0, wr_data.fltr};
    assign wr_word[2] = {16'd0, wr_data.psum};

    // Shared push and pop keep the three FIFOs in lockstep
    for (genvar g = 0; g < 3; g++) begin : g_field
        async_fifo u_fifo (
            .wr_clk     (bus_clk),
            .rd_clk     (pe_clk),
            .arst_n     (arst_n),
            .wr_en      (push),
            .wr_data    (wr_word[g]),
            .full       (full_v[g]),
            .wr_level   (),
            .rd_en      (pop),
            .rd_data    (rd_word[g]),
            .empty      (empty_v[g]),
            .empty_sync (empty_sync_v[g])
        );
    end

    // Rejoin the beat
    assign rd_data.ifmap = rd_word[0][7:0];
    assign rd_data.fltr  = rd_word[1][7:0];
    assign rd_data.psum  = rd_word[2][15:0];

    // Merged flags, any lane blocks the whole beat
    assign full       = |full_v;
    assign empty      = |empty_v;
    assign empty_sync = |empty_sync_v;

endmodule

// File: source/wb_host_port.sv
module wb_host_port
    import conv_pkg::*;
(
    input  logic     bus_clk,
    input  logic     arst_n,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output logic     op_push,
    output operand_t op_data,
    input  logic     op_full,
    input  logic     op_empty_sync,
    output logic     res_pop,
    input  result_t  res_data,
    input  logic     res_empty
);

    logic       ack;
    logic       access;
    logic       wr_operand;
    logic       rd_result;
    logic       wr_clear;
    // Access captured for the ack cycle
    logic       rd_we;
    logic [1:0] rd_adr;
    logic       rd_hit;
    logic       overflow;
    logic       underflow;
    status_t    status;

    // First cycle of a request, ack not yet given
    assign access     = wb_req.cyc && wb_req.stb && !ack;
    assign wr_operand = access && wb_req.we && (wb_req.adr == ADR_OPERAND);
    assign rd_result  = access && !wb_req.we && (wb_req.adr == ADR_RESULT);
    assign wr_clear   = access && wb_req.we && (wb_req.adr == ADR_CLEAR);

    assign op_push = wr_operand && !op_full;
    assign op_data = operand_t'(wb_req.dat);
    assign res_pop = rd_result && !res_empty;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 1'b0;
            rd_we  <= 1'b0;
            rd_adr <= '0;
            rd_hit <= 1'b0;
        end else begin
            ack <= access;
            if (access) begin
                rd_we  <= wb_req.we;
                rd_adr <= wb_req.adr;
                rd_hit <= !res_empty;
            end
        end
    end

    // Sticky error flags
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else if (wr_clear) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (wr_operand && op_full) begin
                overflow <= 1'b1;
            end
            if (rd_result && res_empty) begin
                underflow <= 1'b1;
            end
        end
    end

    always_comb begin
        status           = '0;
        status.overflow  = overflow;
        status.underflow = underflow;
        status.buf_empty = op_empty_sync;
        status.res_avail = !res_empty;
    end

    // Read mux, popped data is valid during ack
    always_comb begin
        wb_rsp.ack = ack;
        wb_rsp.dat = '0;
        if (ack && !rd_we) begin
            case (rd_adr)
                ADR_RESULT: begin
                    // Empty pop reads as zero
                    if (rd_hit) begin
                        wb_rsp.dat.result = res_data;
                    end
                end
                ADR_STATUS: wb_rsp.dat.status = status;
                default:    wb_rsp.dat = '0;
            endcase
        end
    end

endmodule

// File: source/pe_dispatch.sv
module pe_dispatch
    import conv_pkg::*;
(
    input  logic             pe_clk,
    input  logic             arst_n,
    input  logic             buf_empty,
    output logic             buf_pop,
    input  operand_t         buf_data,
    input  logic [FIFO_AW:0] ret_level,
    input  logic             retire,
    output pe_op_t           pe_op [NUM_PE]
);

    // Beats popped but not yet in the return FIFO
    logic [FIFO_AW:0]          in_flight;
    logic [FIFO_AW+1:0]        committed;
    logic                      pop_q;
    logic [$clog2(NUM_PE)-1:0] lane;

    // Return slots already spoken for
    assign committed = ret_level + in_flight;
    assign buf_pop   = !buf_empty && (committed < FIFO_DEPTH);

    always_ff @(posedge pe_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
            pop_q     <= 1'b0;
            lane      <= '0;
        end else begin
            pop_q <= buf_pop;
            case ({buf_pop, retire})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
            // Next lane once the beat has been issued
            if (pop_q) begin
                lane <= (lane == NUM_PE - 1) ? '0 : lane + 1'b1;
            end
        end
    end

    // Buffer data arrives the cycle after the pop
    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            pe_op[i].valid   = pop_q && (lane == i);
            pe_op[i].operand = buf_data;
        end
    end

endmodule

// File: source/conv_pe.sv
module conv_pe
    import conv_pkg::*;
(
    input  logic    pe_clk,
    input  logic    arst_n,
    input  pe_op_t  op,
    output pe_res_t res
);

    logic               s1_valid;
    logic               s2_valid;
    logic signed [15:0] s1_prod;
    logic signed [15:0] s1_psum;
    logic signed [15:0] s2_sum;

    // Valid pipe
    always_ff @(posedge pe_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= op.valid;
            s2_valid <= s1_valid;
        end
    end

    // Stage 1 signed product, 8x8 fits in 16 bits
    always_ff @(posedge pe_clk) begin
        s1_prod <= op.operand.ifmap * op.operand.fltr;
        s1_psum <= op.operand.psum;
    end

    // Stage 2 accumulate, wraps at 16 bits
    always_ff @(posedge pe_clk) begin
        s2_sum <= s1_psum + s1_prod;
    end

    assign res.valid = s2_valid;
    assign res.value = s2_sum;

endmodule

// File: source/psum_collector.sv
module psum_collector
    import conv_pkg::*;
(
    input  logic    pe_clk,
    input  logic    arst_n,
    input  pe_res_t pe_res [NUM_PE],
    output logic    ret_push,
    output result_t ret_data,
    output logic    retire
);

    // Same lane order as the dispatcher
    logic [$clog2(NUM_PE)-1:0] lane;
    pe_res_t                   head;

    assign head = pe_res[lane];

    always_ff @(posedge pe_clk or negedge arst_n) begin
        if (!arst_n) begin
            lane <= '0;
        end else if (head.valid) begin
            lane <= (lane == NUM_PE - 1) ? '0 : lane + 1'b1;
        end
    end

    // One push per valid on the expected lane
    assign ret_push = head.valid;

    // Zero-extended into the bus result word
    always_comb begin
        ret_data       = '0;
        ret_data.value = head.value;
    end

    // Frees a credit in the dispatcher
    assign retire = ret_push;

endmodule

// File: source/conv_top.sv
module conv_top
    import conv_pkg::*;
(
    input  logic    bus_clk,
    input  logic    pe_clk,
    input  logic    arst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    // bus_clk side
    logic             op_push;
    operand_t         op_data;
    logic             op_full;
    logic             op_empty_sync;
    logic             res_pop;
    result_t          res_data;
    logic             res_empty;
    // pe_clk side
    logic             buf_pop;
    operand_t         buf_data;
    logic             buf_empty;
    logic             ret_push;
    result_t          ret_data;
    logic [FIFO_AW:0] ret_level;
    logic             retire;
    pe_op_t           pe_op  [NUM_PE];
    pe_res_t          pe_res [NUM_PE];

    wb_host_port u_host (
        .bus_clk       (bus_clk),
        .arst_n        (arst_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .op_push       (op_push),
        .op_data       (op_data),
        .op_full       (op_full),
        .op_empty_sync (op_empty_sync),
        .res_pop       (res_pop),
        .res_data      (res_data),
        .res_empty     (res_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Operand path, bus_clk to pe_clk
    //////////////////////////////////////////////////////////////////////

    ccd_buffer u_buffer (
        .bus_clk    (bus_clk),
        .pe_clk     (pe_clk),
        .arst_n     (arst_n),
        .push       (op_push),
        .wr_data    (op_data),
        .full       (op_full),
        .pop        (buf_pop),
        .rd_data    (buf_data),
        .empty      (buf_empty),
        .empty_sync (op_empty_sync)
    );

    pe_dispatch u_dispatch (
        .pe_clk    (pe_clk),
        .arst_n    (arst_n),
        .buf_empty (buf_empty),
        .buf_pop   (buf_pop),
        .buf_data  (buf_data),
        .ret_level (ret_level),
        .retire    (retire),
        .pe_op     (pe_op)
    );

    // Element array
    for (genvar g = 0; g < NUM_PE; g++) begin : g_pe
        conv_pe u_pe (
            .pe_clk (pe_clk),
            .arst_n (arst_n),
            .op     (pe_op[g]),
            .res    (pe_res[g])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Return path, pe_clk to bus_clk
    //////////////////////////////////////////////////////////////////////

    psum_collector u_collector (
        .pe_clk   (pe_clk),
        .arst_n   (arst_n),
        .pe_res   (pe_res),
        .ret_push (ret_push),
        .ret_data (ret_data),
        .retire   (retire)
    );

    // Credit check upstream keeps this FIFO from filling past depth
    async_fifo u_ret_fifo (
        .wr_clk     (pe_clk),
        .rd_clk     (bus_clk),
        .arst_n     (arst_n),
        .wr_en      (ret_push),
        .wr_data    (ret_data),
        .full       (),
        .wr_level   (ret_level),
        .rd_en      (res_pop),
        .rd_data    (res_data),
        .empty      (res_empty),
        .empty_sync ()
    );

endmodule

// File: testbench/tb_conv_checks.svh
`ifndef TB_CONV_CHECKS_SVH
`define TB_CONV_CHECKS_SVH

// Bus cycles allowed before ack must show up
localparam int ACK_TIMEOUT = 32;

//////////////////////////////////////////////////////////////////////
// Wishbone classic single accesses
//////////////////////////////////////////////////////////////////////

// Called on a falling edge, returns on a falling edge
task automatic bus_access(
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [31:0] wdat,
    output bus_word_u   rdat
);
    int waited;
    rdat       = '0;
    waited     = 0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    // Ack sampled mid-cycle, away from the rising edge
    do begin
        @(negedge bus_clk);
        waited++;
    end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
    if (wb_rsp.ack) begin
        rdat = wb_rsp.dat;
    end else begin
        other_errors++;
        $display("No ack from the DUT within %0d bus cycles at address %0d", waited, adr);
    end
    wb_req = '0;
    // Idle cycle between accesses
    @(negedge bus_clk);
endtask

task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdat);
    bus_word_u unused;
    bus_access(1'b1, adr, wdat, unused);
endtask

task automatic bus_read(input logic [1:0] adr, output bus_word_u rdat);
    bus_access(1'b0, adr, 32'd0, rdat);
endtask

//////////////////////////////////////////////////////////////////////
// Typed compares
//////////////////////////////////////////////////////////////////////

task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("ERROR wb_rsp.dat.result got 0x%08h expected 0x%08h", got, exp);
    end
endtask

task automatic check_status(input status_t got, input status_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("ERROR wb_rsp.dat.status got 0x%08h expected 0x%08h", got, exp);
    end
endtask

`endif

// File: testbench/tb_conv_top.sv
module tb_conv_top
    import conv_pkg::*;
();

    // Status polls allowed while waiting for a result
    localparam int AVAIL_TIMEOUT = 100;

    // One table row, operand beat and its 16-bit result
    typedef struct packed {
        operand_t    op;
        logic [15:0] value;
    } vector_t;

    logic        bus_clk;
    logic        pe_clk;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state;
    vector_t     vec_table [8];

    `include "tb_conv_checks.svh"

    conv_top u_dut (
        .bus_clk (bus_clk),
        .pe_clk  (pe_clk),
        .arst_n  (arst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // Clocks
    //////////////////////////////////////////////////////////////////////

    initial begin
        bus_clk = 1'b0;
        pe_clk  = 1'b0;
    end

    // bus_clk period 8
    always #4 bus_clk = ~bus_clk;

    // pe_clk period 5, uneven halves
    always begin
        #2 pe_clk = 1'b1;
        #3 pe_clk = 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Whole LCG word taken as one operand beat
    function automatic operand_t rand_operand();
        lcg_state = lcg_next(lcg_state);
        return operand_t'(lcg_state);
    endfunction

    // psum + ifmap * fltr, signed, kept to 16 bits
    function automatic logic [15:0] mac_expect(input operand_t op);
        int full_sum;
        full_sum = $signed(op.psum) + $signed(op.ifmap) * $signed(op.fltr);
        return full_sum[15:0];
    endfunction

    function automatic status_t make_status(
        input logic ovf,
        input logic unf,
        input logic bempty,
        input logic avail
    );
        status_t s;
        s           = '0;
        s.overflow  = ovf;
        s.underflow = unf;
        s.buf_empty = bempty;
        s.res_avail = avail;
        return s;
    endfunction

    function automatic vector_t make_vector(
        input logic [15:0] psum,
        input logic [7:0]  fltr,
        input logic [7:0]  ifmap,
        input logic [15:0] value
    );
        vector_t v;
        v.op.psum  = psum;
        v.op.fltr  = fltr;
        v.op.ifmap = ifmap;
        v.value    = value;
        return v;
    endfunction

    // Expected values worked out by hand
    task automatic load_table();
        vec_table[0] = make_vector(16'h0000, 8'h03, 8'h05, 16'h000F);
        // 100 + 7 * -2
        vec_table[1] = make_vector(16'h0064, 8'hFE, 8'h07, 16'h0056);
        // -1 + -128 * -128
        vec_table[2] = make_vector(16'hFFFF, 8'h80, 8'h80, 16'h3FFF);
        // Positive wrap
        vec_table[3] = make_vector(16'h7FFF, 8'h01, 8'h01, 16'h8000);
        // Negative wrap, -32768 - 16256
        vec_table[4] = make_vector(16'h8000, 8'h7F, 8'h80, 16'h4080);
        vec_table[5] = make_vector(16'h1234, 8'h10, 8'hF0, 16'h1134);
        vec_table[6] = make_vector(16'h0000, 8'h00, 8'h55, 16'h0000);
        // Product cancels the psum
        vec_table[7] = make_vector(16'hFFF6, 8'h05, 8'h02, 16'h0000);
    endtask

    // Poll until a result is readable, then pop and compare
    task automatic pop_expect(input logic [15:0] value);
        bus_word_u rd;
        result_t   exp;
        int        polls;
        logic      avail;
        avail = 1'b0;
        polls = 0;
        while (!avail && polls < AVAIL_TIMEOUT) begin
            bus_read(ADR_STATUS, rd);
            avail = rd.status.res_avail;
            polls++;
        end
        if (!avail) begin
            other_errors++;
            $display("A result never became available after %0d status reads", polls);
        end else begin
            bus_read(ADR_RESULT, rd);
            exp       = '0;
            exp.value = value;
            check_result(rd.result, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bus_word_u   rd;
        operand_t    op;
        logic [15:0] exp_q [$];
        logic [15:0] backlog [20];
        logic [15:0] front;
        arst_n       = 1'b0;
        wb_req       = '0;
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'h1062_10bf;
        load_table();
        repeat (4) @(posedge bus_clk);
        @(negedge bus_clk);
        arst_n = 1'b1;
        @(negedge bus_clk);

        // Idle state after reset
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b0, 1'b0, 1'b1, 1'b0));

        // Table, one beat at a time
        for (int i = 0; i < 8; i++) begin
            bus_write(ADR_OPERAND, vec_table[i].op);
            pop_expect(vec_table[i].value);
        end

        // Back-pressure, 16 fit and 4 are dropped
        for (int i = 0; i < 20; i++) begin
            op         = rand_operand();
            backlog[i] = mac_expect(op);
            bus_write(ADR_OPERAND, op);
        end
        repeat (200) @(negedge bus_clk);
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b1, 1'b0, 1'b0, 1'b1));
        for (int k = 0; k < 16; k++) begin
            pop_expect(backlog[k]);
        end
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b1, 1'b0, 1'b1, 1'b0));
        // Empty pop reads zero
        bus_read(ADR_RESULT, rd);
        check_result(rd.result, '0);
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b1, 1'b1, 1'b1, 1'b0));

        // Sticky flags cleared, the rest untouched
        bus_write(ADR_CLEAR, 32'd0);
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b0, 1'b0, 1'b1, 1'b0));

        // Random burst with pops in between
        for (int i = 0; i < 12; i++) begin
            op = rand_operand();
            exp_q.push_back(mac_expect(op));
            bus_write(ADR_OPERAND, op);
            if (i % 2 == 1) begin
                front = exp_q.pop_front();
                pop_expect(front);
            end
        end
        while (exp_q.size() > 0) begin
            front = exp_q.pop_front();
            pop_expect(front);
        end
        bus_read(ADR_STATUS, rd);
        check_status(rd.status, make_status(1'b0, 1'b0, 1'b1, 1'b0));

        $display("Checks done with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+testbench
source/conv_pkg.sv
source/async_fifo.sv
source/ccd_buffer.sv
source/wb_host_port.sv
source/pe_dispatch.sv
source/conv_pe.sv
source/psum_collector.sv
source/conv_top.sv
testbench/tb_conv_top.sv
